// ==== tb.f ====
source/immu_pkg.sv
source/tlb_ram.sv
source/tlb_clear_counter.sv
source/immu_ctrl.sv
source/tlb_lookup.sv
source/pc_tracker.sv
source/immu_top.sv
tests/tb_immu.sv

// ==== Bender.yml ====
package:
  name: immu

sources:
  # Shared definitions first
  - source/immu_pkg.sv
  # Design
  - source/tlb_ram.sv
  - source/tlb_clear_counter.sv
  - source/immu_ctrl.sv
  - source/tlb_lookup.sv
  - source/pc_tracker.sv
  - source/immu_top.sv
  # Testbench
  - target: test
    files:
      - tests/tb_immu.sv

// ==== tests/immu_trace.txt ====
// Columns op_a_b_c in hex. op 1/2 TLB low/high write (a index, b data), 3 mode (a imme, b rm)
// 4 fetch (a addr, b 0 plain 1 flush 2 flush over pending c), 5 expect (a phys, b fault, c id)
// 6 readback (a 0 low 1 high, b index, c data), f end. Fault 0 none, 1 TLB miss, 2 page
// Translation off
3_00000000_00000000_00000000
4_00000100_00000000_00000000
5_00000100_00000000_00000100
4_00000104_00000000_00000000
5_00000104_00000000_00000104
// Cleared entries read zero
6_00000000_00000007_00000000
6_00000001_00000007_00000000
// Entry 1 user and supervisor execute, entry 2 supervisor only, entry 3 invalid
1_00000001_00002001_00000000
2_00000001_00082018_00000000
1_00000002_00024001_00000000
2_00000002_00200010_00000000
1_00000003_00006000_00000000
2_00000003_00008018_00000000
6_00000000_00000001_00002001
6_00000001_00000002_00200010
// User mode hit, page faults and misses
3_00000001_00000000_00000000
4_00002004_00000000_00000000
5_00082004_00000000_00002004
4_00024100_00000000_00000000
5_00000000_00000002_00002004
4_00006008_00000000_00000000
5_00000000_00000001_00002004
4_00022000_00000000_00000000
5_00000000_00000001_00002004
4_0000e000_00000000_00000000
5_00000000_00000002_00002004
// Supervisor mode
3_00000001_00000001_00000000
4_00024100_00000000_00000000
5_00200100_00000000_00024100
4_00025ffc_00000000_00000000
5_00201ffc_00000000_00025ffc
// Flushes
4_00024200_00000001_00000000
5_00200200_00000000_00024200
4_00002010_00000002_00002008
5_00082010_00000000_00002010
3_00000000_00000000_00000000
4_00000300_00000002_00000200
5_00000300_00000000_00000300
f_00000000_00000000_00000000

// ==== tests/tb_immu.sv ====
// Instruction MMU testbench
// Replays a trace of TLB writes, mode changes and fetches against the DUT,
// with a cache model that stalls at random and answers with tagged data

module tb_immu import immu_pkg::*; ();

   localparam logic [DW-1:0] DATA_KEY        = 32'hA5A5_0000;
   localparam int            TRACE_DEPTH     = 64;
   localparam int            CYCLES_PER_LINE = 40;
   localparam int            RESET_CYCLES    = 3;

   logic                 clk;
   logic                 rst_n;
   logic                 ibus_cmd_valid;
   logic                 ibus_cmd_ready;
   logic [AW-1:0]        ibus_cmd_addr;
   logic                 ibus_cmd_flush;
   logic                 ibus_flush_ack;
   logic                 ibus_dout_valid;
   logic                 ibus_dout_ready;
   logic [DW-1:0]        ibus_dout;
   logic [AW-1:0]        ibus_out_id;
   logic [AW-1:0]        ibus_out_id_nxt;
   logic                 icache_cmd_valid;
   logic                 icache_cmd_ready;
   logic [AW-1:0]        icache_cmd_addr;
   logic                 icache_dout_valid;
   logic                 icache_dout_ready;
   logic [DW-1:0]        icache_dout;
   logic                 exp_imm_tlb_miss;
   logic                 exp_imm_page_fault;
   logic                 msr_psr_imme;
   logic                 msr_psr_rm;
   logic                 msr_imm_tlbl_we;
   logic [TLB_IDX_W-1:0] msr_imm_tlbl_idx;
   logic [DW-1:0]        msr_imm_tlbl_nxt;
   logic [DW-1:0]        msr_imm_tlbl;
   logic                 msr_imm_tlbh_we;
   logic [TLB_IDX_W-1:0] msr_imm_tlbh_idx;
   logic [DW-1:0]        msr_imm_tlbh_nxt;
   logic [DW-1:0]        msr_imm_tlbh;

   // Trace record: op, then three 32-bit fields
   logic [99:0]   trace_mem [TRACE_DEPTH];
   integer        seed;
   int            cycles       = 0;
   int            cycle_limit  = 1000;
   int            ack_count    = 0;
   int            errors       = 0;
   int            tests        = 0;
   int            tests_failed = 0;
   logic          hs_seen;
   logic [AW-1:0] hs_addr;

   immu_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Cache model, timeout and flush acknowledge counter
   ////////////////////////////////////////////////////////////////////////////

   // Command handshake seen on the rising edge
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hs_seen <= 1'b0;
         hs_addr <= '0;
      end else begin
         hs_seen <= icache_cmd_valid && icache_cmd_ready;
         if (icache_cmd_valid && icache_cmd_ready) begin
            hs_addr <= icache_cmd_addr;
         end
      end
   end

   // Data one cycle after the handshake, ready stalls a quarter of the time
   always @(negedge clk) begin
      icache_cmd_ready  <= rst_n && (($random(seed) & 3) != 0);
      icache_dout_valid <= hs_seen;
      icache_dout       <= hs_seen ? (hs_addr ^ DATA_KEY) : '0;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (ibus_flush_ack) begin
         ack_count <= ack_count + 1;
      end
      if (cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, the trace did not finish", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_addr(input string name, input logic [AW-1:0] got,
                             input logic [AW-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_data(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_fault(input string name, input fault_e got, input fault_e exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at time %0t: %s got %s expected %s", $time, name,
                  got.name(), exp.name());
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         errors++;
         $display("Mismatch at time %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // Fault kind shown by the two strobes
   function automatic fault_e observed_fault();
      if (exp_imm_tlb_miss) begin
         return FAULT_TLB_MISS;
      end else if (exp_imm_page_fault) begin
         return FAULT_PAGE;
      end
      return FAULT_NONE;
   endfunction

   task automatic finish_test(input string what, input int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("Test %0d %s: passed", tests, what);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed", tests, what);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus drivers, all entered and left on a falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic write_tlb(input logic high, input logic [TLB_IDX_W-1:0] idx,
                            input logic [DW-1:0] data);
      if (high) begin
         msr_imm_tlbh_we  = 1'b1;
         msr_imm_tlbh_idx = idx;
         msr_imm_tlbh_nxt = data;
      end else begin
         msr_imm_tlbl_we  = 1'b1;
         msr_imm_tlbl_idx = idx;
         msr_imm_tlbl_nxt = data;
      end
      @(negedge clk);
      msr_imm_tlbl_we = 1'b0;
      msr_imm_tlbh_we = 1'b0;
      // Readback shows the new word one cycle after the write
      if (high) begin
         check_data("msr_imm_tlbh", msr_imm_tlbh, data);
      end else begin
         check_data("msr_imm_tlbl", msr_imm_tlbl, data);
      end
   endtask

   task automatic read_tlb(input logic high, input logic [TLB_IDX_W-1:0] idx,
                           input logic [DW-1:0] exp);
      if (high) begin
         msr_imm_tlbh_idx = idx;
      end else begin
         msr_imm_tlbl_idx = idx;
      end
      @(negedge clk);
      if (high) begin
         check_data("msr_imm_tlbh", msr_imm_tlbh, exp);
      end else begin
         check_data("msr_imm_tlbl", msr_imm_tlbl, exp);
      end
   endtask

   // Kind 0 plain, 1 flush from ready, 2 flush over a pending command
   task automatic run_fetch(input logic [AW-1:0] addr, input logic [AW-1:0] kind,
                            input logic [AW-1:0] dropped, input logic [AW-1:0] exp_addr,
                            input fault_e exp_fault, input logic [AW-1:0] exp_id);
      int acks_before;
      acks_before = ack_count;
      while (!ibus_cmd_ready) begin
         @(negedge clk);
      end
      ibus_cmd_valid = 1'b1;
      if (kind == 2) begin
         // Sits in lookup when the flush replaces it
         ibus_cmd_addr  = dropped;
         ibus_cmd_flush = 1'b0;
         @(negedge clk);
      end
      ibus_cmd_addr  = addr;
      ibus_cmd_flush = (kind != 0);
      @(negedge clk);
      ibus_cmd_valid = 1'b0;
      ibus_cmd_flush = 1'b0;
      // Next id follows the command that went to lookup
      check_addr("ibus_out_id_nxt", ibus_out_id_nxt, addr);

      // Either a cache command or a fault strobe
      while (!(icache_cmd_valid || exp_imm_tlb_miss || exp_imm_page_fault)) begin
         @(negedge clk);
      end
      if (exp_imm_tlb_miss && exp_imm_page_fault) begin
         errors++;
         $display("Both fault strobes are high together at time %0t", $time);
      end
      check_fault("fault", observed_fault(), exp_fault);
      if (icache_cmd_valid) begin
         // Address holds while the cache stalls
         while (icache_cmd_valid) begin
            check_addr("icache_cmd_addr", icache_cmd_addr, exp_addr);
            @(negedge clk);
         end
         do begin
            @(posedge clk);
         end while (!(ibus_dout_valid && ibus_dout_ready));
         check_data("ibus_dout", ibus_dout, exp_addr ^ DATA_KEY);
         check_bit("icache_dout_ready", icache_dout_ready, 1'b1);
         @(negedge clk);
      end else begin
         // Strobe lasts one cycle, and nothing goes to the cache
         @(negedge clk);
         check_fault("fault after strobe", observed_fault(), FAULT_NONE);
         check_bit("icache_cmd_valid", icache_cmd_valid, 1'b0);
      end
      check_addr("ibus_out_id", ibus_out_id, exp_id);
      check_count("ibus_flush_ack pulses", ack_count - acks_before, (kind != 0) ? 1 : 0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int            line;
      int            lines;
      int            errors_before;
      int            clear_cycles;
      logic [3:0]    op;
      logic [AW-1:0] fa;
      logic [AW-1:0] fb;
      logic [AW-1:0] fc;
      logic [99:0]   res;

      seed              = 32'h3be6;
      rst_n             = 1'b0;
      ibus_cmd_valid    = 1'b0;
      ibus_cmd_addr     = '0;
      ibus_cmd_flush    = 1'b0;
      ibus_dout_ready   = 1'b1;
      icache_cmd_ready  = 1'b0;
      icache_dout_valid = 1'b0;
      icache_dout       = '0;
      msr_psr_imme      = 1'b0;
      msr_psr_rm        = 1'b0;
      msr_imm_tlbl_we   = 1'b0;
      msr_imm_tlbl_idx  = '0;
      msr_imm_tlbl_nxt  = '0;
      msr_imm_tlbh_we   = 1'b0;
      msr_imm_tlbh_idx  = '0;
      msr_imm_tlbh_nxt  = '0;

      // Trace ends at an f record
      $readmemh("tests/immu_trace.txt", trace_mem);
      lines = 0;
      while ((lines < TRACE_DEPTH) && !$isunknown(trace_mem[lines][99:96]) &&
             (trace_mem[lines][99:96] != 4'hf)) begin
         lines++;
      end
      cycle_limit = lines * CYCLES_PER_LINE + TLB_ENTRIES + RESET_CYCLES;

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Quiet outputs, then ready after exactly one sweep
      errors_before = errors;
      check_bit("icache_cmd_valid", icache_cmd_valid, 1'b0);
      check_bit("exp_imm_tlb_miss", exp_imm_tlb_miss, 1'b0);
      check_bit("exp_imm_page_fault", exp_imm_page_fault, 1'b0);
      check_bit("ibus_flush_ack", ibus_flush_ack, 1'b0);
      clear_cycles = 0;
      while (!ibus_cmd_ready) begin
         clear_cycles++;
         @(negedge clk);
      end
      check_count("clear sweep cycles", clear_cycles, TLB_ENTRIES);
      finish_test("reset and clear sweep", errors_before);

      line = 0;
      while (line < lines) begin
         op            = trace_mem[line][99:96];
         fa            = trace_mem[line][95:64];
         fb            = trace_mem[line][63:32];
         fc            = trace_mem[line][31:0];
         errors_before = errors;
         case (op)
            4'h1: begin
               write_tlb(1'b0, fa[TLB_IDX_W-1:0], fb);
               finish_test("TLB low write", errors_before);
            end
            4'h2: begin
               write_tlb(1'b1, fa[TLB_IDX_W-1:0], fb);
               finish_test("TLB high write", errors_before);
            end
            4'h3: begin
               msr_psr_imme = fa[0];
               msr_psr_rm   = fb[0];
            end
            4'h4: begin
               res = trace_mem[line + 1];
               if ((line + 1 >= lines) || (res[99:96] != 4'h5)) begin
                  errors++;
                  $display("Trace line %0d holds a fetch without an expected result", line);
               end else begin
                  run_fetch(fa, fb, fc, res[95:64], fault_e'(res[33:32]), res[31:0]);
                  finish_test($sformatf("fetch %h", fa), errors_before);
                  line++;
               end
            end
            4'h6: begin
               read_tlb(fa[0], fb[TLB_IDX_W-1:0], fc);
               finish_test("TLB readback", errors_before);
            end
            default: begin
               errors++;
               $display("Trace line %0d holds an unknown record type %h", line, op);
            end
         endcase
         line++;
      end

      $display("Tests run %0d, tests failed %0d, check errors %0d", tests, tests_failed, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== source/immu_top.sv ====
// Instruction MMU top level
// Sits between the fetch bus and the instruction cache, with a
// direct-mapped TLB written through the MSR ports

module immu_top import immu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   // Fetch command
   input  logic                 ibus_cmd_valid,
   output logic                 ibus_cmd_ready,
   input  logic [AW-1:0]        ibus_cmd_addr,
   input  logic                 ibus_cmd_flush,
   output logic                 ibus_flush_ack,
   // Fetch data
   output logic                 ibus_dout_valid,
   input  logic                 ibus_dout_ready,
   output logic [DW-1:0]        ibus_dout,
   output logic [AW-1:0]        ibus_out_id,
   output logic [AW-1:0]        ibus_out_id_nxt,
   // Cache command
   output logic                 icache_cmd_valid,
   input  logic                 icache_cmd_ready,
   output logic [AW-1:0]        icache_cmd_addr,
   // Cache data
   input  logic                 icache_dout_valid,
   output logic                 icache_dout_ready,
   input  logic [DW-1:0]        icache_dout,
   // Exceptions
   output logic                 exp_imm_tlb_miss,
   output logic                 exp_imm_page_fault,
   // Processor status
   input  logic                 msr_psr_imme,
   input  logic                 msr_psr_rm,
   // TLB low half
   input  logic                 msr_imm_tlbl_we,
   input  logic [TLB_IDX_W-1:0] msr_imm_tlbl_idx,
   input  logic [DW-1:0]        msr_imm_tlbl_nxt,
   output logic [DW-1:0]        msr_imm_tlbl,
   // TLB high half
   input  logic                 msr_imm_tlbh_we,
   input  logic [TLB_IDX_W-1:0] msr_imm_tlbh_idx,
   input  logic [DW-1:0]        msr_imm_tlbh_nxt,
   output logic [DW-1:0]        msr_imm_tlbh
);

   logic                 clear_we;
   logic [TLB_IDX_W-1:0] clear_idx;
   logic                 clear_done;
   logic                 tlb_read;
   logic                 capture;
   fault_e               lookup_fault;
   logic [TLB_IDX_W-1:0] tlb_idx;
   logic [DW-1:0]        tlbl_data;
   logic [DW-1:0]        tlbh_data;
   logic                 tlbl_wr_en;
   logic [TLB_IDX_W-1:0] tlbl_wr_idx;
   logic [DW-1:0]        tlbl_wr_data;
   logic                 tlbh_wr_en;
   logic [TLB_IDX_W-1:0] tlbh_wr_idx;
   logic [DW-1:0]        tlbh_wr_data;

   // Cache data goes straight through
   assign ibus_dout_valid   = icache_dout_valid;
   assign ibus_dout         = icache_dout;
   assign icache_dout_ready = ibus_dout_ready;

   ////////////////////////////////////////////////////////////////////////////
   // TLB write ports
   ////////////////////////////////////////////////////////////////////////////

   // Sweep owns the index while clearing
   assign tlbl_wr_en   = clear_we | msr_imm_tlbl_we;
   assign tlbl_wr_idx  = clear_we ? clear_idx : msr_imm_tlbl_idx;
   assign tlbl_wr_data = msr_imm_tlbl_we ? msr_imm_tlbl_nxt : '0;

   assign tlbh_wr_en   = clear_we | msr_imm_tlbh_we;
   assign tlbh_wr_idx  = clear_we ? clear_idx : msr_imm_tlbh_idx;
   assign tlbh_wr_data = msr_imm_tlbh_we ? msr_imm_tlbh_nxt : '0;

   ////////////////////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////////////////////

   immu_ctrl i_ctrl (
      .clk                (clk),
      .rst_n              (rst_n),
      .clear_done         (clear_done),
      .ibus_cmd_valid     (ibus_cmd_valid),
      .ibus_cmd_flush     (ibus_cmd_flush),
      .ibus_cmd_ready     (ibus_cmd_ready),
      .ibus_flush_ack     (ibus_flush_ack),
      .tlb_read           (tlb_read),
      .capture            (capture),
      .lookup_fault       (lookup_fault),
      .icache_cmd_valid   (icache_cmd_valid),
      .icache_cmd_ready   (icache_cmd_ready),
      .exp_imm_tlb_miss   (exp_imm_tlb_miss),
      .exp_imm_page_fault (exp_imm_page_fault)
   );

   tlb_clear_counter i_clear (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear_we   (clear_we),
      .clear_idx  (clear_idx),
      .clear_done (clear_done)
   );

   // Low half, valid bit and VPN tag
   tlb_ram i_tlbl (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear_done (clear_done),
      .rd_en      (tlb_read),
      .rd_idx     (tlb_idx),
      .rd_data    (tlbl_data),
      .wr_en      (tlbl_wr_en),
      .wr_idx     (tlbl_wr_idx),
      .wr_data    (tlbl_wr_data),
      .rb_data    (msr_imm_tlbl)
   );

   // High half, permissions and PPN
   tlb_ram i_tlbh (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear_done (clear_done),
      .rd_en      (tlb_read),
      .rd_idx     (tlb_idx),
      .rd_data    (tlbh_data),
      .wr_en      (tlbh_wr_en),
      .wr_idx     (tlbh_wr_idx),
      .wr_data    (tlbh_wr_data),
      .rb_data    (msr_imm_tlbh)
   );

   tlb_lookup i_lookup (
      .clk             (clk),
      .rst_n           (rst_n),
      .capture         (capture),
      .ibus_cmd_addr   (ibus_cmd_addr),
      .msr_psr_imme    (msr_psr_imme),
      .msr_psr_rm      (msr_psr_rm),
      .tlbl_data       (tlbl_data),
      .tlbh_data       (tlbh_data),
      .lookup_fault    (lookup_fault),
      .icache_cmd_addr (icache_cmd_addr),
      .tlb_idx         (tlb_idx)
   );

   pc_tracker i_pc (
      .clk             (clk),
      .rst_n           (rst_n),
      .capture         (capture),
      .ibus_cmd_flush  (ibus_cmd_flush),
      .ibus_cmd_addr   (ibus_cmd_addr),
      .ibus_dout_valid (icache_dout_valid),
      .ibus_dout_ready (ibus_dout_ready),
      .ibus_out_id     (ibus_out_id),
      .ibus_out_id_nxt (ibus_out_id_nxt)
   );

endmodule

// ==== source/pc_tracker.sv ====
// Fetch address tracker
// Follows the address of the next lookup and of the delivered instruction

module pc_tracker import immu_pkg::*; (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          capture,
   input  logic          ibus_cmd_flush,
   input  logic [AW-1:0] ibus_cmd_addr,
   input  logic          ibus_dout_valid,
   input  logic          ibus_dout_ready,
   output logic [AW-1:0] ibus_out_id,
   output logic [AW-1:0] ibus_out_id_nxt
);

   logic          dout_hs;
   logic [AW-1:0] id_bypass;

   assign dout_hs = ibus_dout_valid && ibus_dout_ready;

   // Flushing command address goes straight to the delivered id
   assign id_bypass = ibus_cmd_flush ? ibus_cmd_addr : ibus_out_id_nxt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ibus_out_id_nxt <= RESET_VECTOR - AW'(4);
         ibus_out_id     <= RESET_VECTOR;
      end else begin
         // Next id follows the command sent to lookup
         if (capture) begin
            ibus_out_id_nxt <= ibus_cmd_addr;
         end
         // Delivered id moves with each instruction handed out
         if (dout_hs) begin
            ibus_out_id <= id_bypass;
         end
      end
   end

endmodule

// ==== source/tlb_lookup.sv ====
// TLB compare and address translation
// Captures the command, checks tag and execute permission,
// and forms the physical address

module tlb_lookup import immu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 capture,
   input  logic [AW-1:0]        ibus_cmd_addr,
   input  logic                 msr_psr_imme,
   input  logic                 msr_psr_rm,
   input  logic [DW-1:0]        tlbl_data,
   input  logic [DW-1:0]        tlbh_data,
   output fault_e               lookup_fault,
   output logic [AW-1:0]        icache_cmd_addr,
   output logic [TLB_IDX_W-1:0] tlb_idx
);

   logic [VPN_W-1:0]      vpn_r;
   logic [PAGE_SHIFT-1:0] offset_r;
   logic [AW-1:0]         raw_addr_r;
   logic                  imme_r;
   logic                  rm_r;
   logic                  tlb_v;
   logic                  tlb_ux;
   logic                  tlb_rx;
   logic [VPN_W-1:0]      tlb_vpn;
   logic [PPN_W-1:0]      tlb_ppn;
   logic                  perm_denied;
   logic                  tlb_hit;

   // Index must fit inside the VPN
   if (!TLB_IDX_OK) begin : g_idx_check
      $error("TLB index wider than the VPN");
   end

   // Index from the incoming command, read in the handshake cycle
   assign tlb_idx = ibus_cmd_addr[PAGE_SHIFT +: TLB_IDX_W];

   ////////////////////////////////////////////////////////////////////////////
   // Request capture
   ////////////////////////////////////////////////////////////////////////////

   // Mode bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imme_r <= 1'b0;
         rm_r   <= 1'b0;
      end else if (capture) begin
         imme_r <= msr_psr_imme;
         rm_r   <= msr_psr_rm;
      end
   end

   // Address fields
   always_ff @(posedge clk) begin
      if (capture) begin
         vpn_r      <= ibus_cmd_addr[AW-1 -: VPN_W];
         offset_r   <= ibus_cmd_addr[PAGE_SHIFT-1:0];
         raw_addr_r <= ibus_cmd_addr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Entry decode and checks
   ////////////////////////////////////////////////////////////////////////////

   assign tlb_v   = tlbl_data[TLBL_V_BIT];
   assign tlb_vpn = tlbl_data[DW-1 -: VPN_W];
   assign tlb_ux  = tlbh_data[TLBH_UX_BIT];
   assign tlb_rx  = tlbh_data[TLBH_RX_BIT];
   assign tlb_ppn = tlbh_data[DW-1 -: PPN_W];

   // Supervisor needs RX, user needs UX
   assign perm_denied = rm_r ? ~tlb_rx : ~tlb_ux;
   assign tlb_hit     = tlb_v && (tlb_vpn == vpn_r);

   // Page fault wins over a miss
   always_comb begin
      if (!imme_r) begin
         lookup_fault = FAULT_NONE;
      end else if (perm_denied) begin
         lookup_fault = FAULT_PAGE;
      end else if (!tlb_hit) begin
         lookup_fault = FAULT_TLB_MISS;
      end else begin
         lookup_fault = FAULT_NONE;
      end
   end

   // Stable until the next capture, as all sources are registered
   assign icache_cmd_addr = imme_r ? {tlb_ppn, offset_r} : raw_addr_r;

endmodule

// ==== source/immu_ctrl.sv ====
// Instruction MMU controller
// Sequences clear, ready, lookup and issue, owns the bus handshakes,
// the flush acknowledge and the fault strobes

module immu_ctrl import immu_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   clear_done,
   // Fetch command
   input  logic   ibus_cmd_valid,
   input  logic   ibus_cmd_flush,
   output logic   ibus_cmd_ready,
   output logic   ibus_flush_ack,
   // Lookup control
   output logic   tlb_read,
   output logic   capture,
   input  fault_e lookup_fault,
   // Cache command
   output logic   icache_cmd_valid,
   input  logic   icache_cmd_ready,
   // Exceptions
   output logic   exp_imm_tlb_miss,
   output logic   exp_imm_page_fault
);

   immu_state_e state;
   immu_state_e state_nxt;
   logic        flush_take;
   logic        take;
   logic        lookup_done;

   assign ibus_cmd_ready = (state == ST_READY);

   // Flush overrides a pending command in lookup or issue
   assign flush_take = ibus_cmd_valid && ibus_cmd_flush &&
                       ((state == ST_LOOKUP) || (state == ST_ISSUE));

   // New command goes to lookup
   assign take     = (ibus_cmd_valid && ibus_cmd_ready) || flush_take;
   assign tlb_read = take;
   assign capture  = take;

   // Lookup cycle ends without being replaced
   assign lookup_done = (state == ST_LOOKUP) && !take;

   // Dropped in the flush cycle so the cache never sees a stale command
   assign icache_cmd_valid = (state == ST_ISSUE) && !flush_take;

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      unique case (state)
         ST_CLEAR: begin
            if (clear_done) begin
               state_nxt = ST_READY;
            end
         end
         ST_READY: begin
            if (take) begin
               state_nxt = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            // Faulting command never reaches the cache
            if (take) begin
               state_nxt = ST_LOOKUP;
            end else if (lookup_fault != FAULT_NONE) begin
               state_nxt = ST_READY;
            end else begin
               state_nxt = ST_ISSUE;
            end
         end
         ST_ISSUE: begin
            if (take) begin
               state_nxt = ST_LOOKUP;
            end else if (icache_cmd_ready) begin
               state_nxt = ST_READY;
            end
         end
         default: state_nxt = ST_CLEAR;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state              <= ST_CLEAR;
         exp_imm_tlb_miss   <= 1'b0;
         exp_imm_page_fault <= 1'b0;
         ibus_flush_ack     <= 1'b0;
      end else begin
         state              <= state_nxt;
         // One-cycle strobes
         exp_imm_tlb_miss   <= lookup_done && (lookup_fault == FAULT_TLB_MISS);
         exp_imm_page_fault <= lookup_done && (lookup_fault == FAULT_PAGE);
         ibus_flush_ack     <= take && ibus_cmd_flush;
      end
   end

   // A fault strobe is alone and never comes with a cache command
   a_fault_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      (exp_imm_tlb_miss || exp_imm_page_fault) |->
         ($onehot({exp_imm_tlb_miss, exp_imm_page_fault}) && !icache_cmd_valid))
      else $error("Fault strobes overlap or come with a cache command");

   // Fetch side protocol
   a_flush_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_cmd_flush |-> ibus_cmd_valid)
      else $error("Flush without a valid fetch command");

endmodule

// ==== source/tlb_clear_counter.sv ====
// TLB clear sweep after reset
// Walks every index once, then holds a sticky done flag

module tlb_clear_counter import immu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   output logic                 clear_we,
   output logic [TLB_IDX_W-1:0] clear_idx,
   output logic                 clear_done
);

   logic [TLB_IDX_W-1:0] cnt;
   logic                 done_r;
   logic                 last;

   // Final index of the sweep
   assign last = (cnt == TLB_IDX_W'(TLB_ENTRIES - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt    <= '0;
         done_r <= 1'b0;
      end else if (!done_r) begin
         // Wraps back to zero after the last entry
         cnt <= cnt + 1'b1;
         if (last) begin
            done_r <= 1'b1;
         end
      end
   end

   assign clear_we  = ~done_r;
   assign clear_idx = cnt;

   // Done already in the last write cycle
   // so the FSM leaves clear on the same edge as the final write
   assign clear_done = done_r | last;

endmodule

// ==== source/tlb_ram.sv ====
// One half of the direct-mapped TLB
// Registered lookup port plus a shared write and readback port

module tlb_ram import immu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 clear_done,
   // Lookup port
   input  logic                 rd_en,
   input  logic [TLB_IDX_W-1:0] rd_idx,
   output logic [DW-1:0]        rd_data,
   // Write and readback port
   input  logic                 wr_en,
   input  logic [TLB_IDX_W-1:0] wr_idx,
   input  logic [DW-1:0]        wr_data,
   output logic [DW-1:0]        rb_data
);

   logic [DW-1:0] mem [TLB_ENTRIES];

   // Entry storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_idx] <= wr_data;
      end
   end

   // Both read ports are write-first
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;
         rb_data <= '0;
      end else begin
         // Lookup data only moves on a new command
         if (rd_en) begin
            if (wr_en && (wr_idx == rd_idx)) begin
               rd_data <= wr_data;
            end else begin
               rd_data <= mem[rd_idx];
            end
         end
         // Readback always follows the write index
         if (wr_en) begin
            rb_data <= wr_data;
         end else begin
            rb_data <= mem[wr_idx];
         end
      end
   end

   // Only the sweep writes while clearing, and it writes zeros
   a_no_msr_write_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_en && !clear_done) |-> (wr_data == '0))
      else $error("MSR write to TLB during clear sweep");

endmodule

// ==== source/immu_pkg.sv ====
// Instruction MMU shared definitions
// Bus widths, page geometry, TLB entry layout and FSM encodings

package immu_pkg;

   // Bus widths
   localparam int AW = 32;
   localparam int DW = 32;

   // Page geometry
   localparam int PAGE_SHIFT = 13;
   localparam int VPN_W      = AW - PAGE_SHIFT;
   localparam int PPN_W      = AW - PAGE_SHIFT;

   // Direct-mapped TLB, indexed by the low VPN bits
   localparam int TLB_IDX_W   = 4;
   localparam int TLB_ENTRIES = 1 << TLB_IDX_W;

   // Index must fit inside the VPN
   localparam bit TLB_IDX_OK = (TLB_IDX_W <= VPN_W);

   ////////////////////////////////////////////////////////////////////////////
   // TLB entry layout
   ////////////////////////////////////////////////////////////////////////////

   // Low half holds valid bit and tag
   localparam int TLBL_V_BIT = 0;

   // High half holds permissions and the frame number
   localparam int TLBH_UX_BIT = 3;
   localparam int TLBH_RX_BIT = 4;

   // Id of the first delivered instruction
   localparam logic [AW-1:0] RESET_VECTOR = 32'h0000_0000;

   ////////////////////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_CLEAR,
      ST_READY,
      ST_LOOKUP,
      ST_ISSUE
   } immu_state_e;

   typedef enum logic [1:0] {
      FAULT_NONE,
      FAULT_TLB_MISS,
      FAULT_PAGE
   } fault_e;

endpackage
